// ==== hdl/ntm_arith_pkg.sv ====
// Arithmetic and matrix types
`default_nettype none

package ntm_arith_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and dimensions
  //////////////////////////////////////////////////////////////////////

  // Element, modulus and result width
  localparam int DATA_W = 12;

  // Largest row or column count
  localparam int MAX_DIM = 4;

  // Words per matrix
  localparam int ELEMS = MAX_DIM * MAX_DIM;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // One element, the modulus or one result
  typedef logic [DATA_W-1:0] elem_t;

  // Row or column count, 1..MAX_DIM
  typedef logic [$clog2(MAX_DIM+1)-1:0] dim_t;

  // Linear index i*MAX_DIM + j
  typedef logic [$clog2(ELEMS)-1:0] idx_t;

  // Divider lane FSM
  typedef enum logic [1:0] {
    IDLE,
    SEARCH,
    HOLD
  } lane_state_t;

endpackage

`default_nettype wire

// ==== hdl/ntm_apb_pkg.sv ====
// APB register map
`default_nettype none

package ntm_apb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W  = 8;
  localparam int PDATA_W = 32;

  typedef logic [ADDR_W-1:0] apb_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  // Bit 0 starts a run
  localparam apb_addr_t CTRL_OFS   = 8'h00;
  // Busy, sticky done, sticky error
  localparam apb_addr_t STATUS_OFS = 8'h04;
  localparam apb_addr_t MOD_OFS    = 8'h08;
  // SIZE_I in 2:0, SIZE_J in 6:4
  localparam apb_addr_t SIZE_OFS   = 8'h0C;

  //////////////////////////////////////////////////////////////////////
  // Matrix windows, 16 words each
  //////////////////////////////////////////////////////////////////////

  localparam apb_addr_t A_BASE = 8'h40;
  localparam apb_addr_t B_BASE = 8'h80;
  localparam apb_addr_t R_BASE = 8'hC0;

endpackage

`default_nettype wire

// ==== hdl/ntm_div_lane_if.sv ====
// Sequencer to divider lane link
`timescale 1ns/100ps
`default_nettype none

interface ntm_div_lane_if import ntm_arith_pkg::*; ();

  // Request side
  logic  start;
  elem_t a;
  elem_t b;
  elem_t modulo;
  idx_t  tag;
  logic  ack;

  // Response side
  logic  idle;
  logic  done;
  elem_t result;
  logic  error;
  idx_t  tag_out;

  // Sequencer end
  modport seq (
    output start, a, b, modulo, tag, ack,
    input  idle, done, result, error, tag_out
  );

  // Lane end
  modport lane (
    input  start, a, b, modulo, tag, ack,
    output idle, done, result, error, tag_out
  );

endinterface

`default_nettype wire

// ==== hdl/ntm_modular_divider.sv ====
// Modular divider lane
`timescale 1ns/100ps
`default_nettype none

module ntm_modular_divider import ntm_arith_pkg::*; (
  input wire           CLK,
  input wire           RST,
  ntm_div_lane_if.lane lane
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  lane_state_t state;

  // Operands, reduced mod M on capture
  elem_t a_r;
  elem_t b_r;
  elem_t m_r;
  idx_t  tag_r;

  // Running a*x mod M and the candidate x
  elem_t acc;
  elem_t x;

  // Held answer
  elem_t res;
  logic  err;

  logic [DATA_W:0] sum;
  elem_t           acc_next;
  logic            hit;
  logic            last_x;

  //////////////////////////////////////////////////////////////////////
  // Search step
  //////////////////////////////////////////////////////////////////////

  // Both terms below M so one subtraction is enough
  assign sum      = {1'b0, acc} + {1'b0, a_r};
  assign acc_next = (sum >= {1'b0, m_r}) ? elem_t'(sum - {1'b0, m_r}) : elem_t'(sum);

  assign hit    = (acc == b_r);
  assign last_x = (x == m_r - 1'b1);

  // FSM
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (lane.start) begin
            state <= SEARCH;
          end
        end
        SEARCH: begin
          // Stop on a match or after the last candidate
          if (hit || last_x) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (lane.ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == IDLE && lane.start) begin
      a_r   <= lane.a % lane.modulo;
      b_r   <= lane.b % lane.modulo;
      m_r   <= lane.modulo;
      tag_r <= lane.tag;
      acc   <= '0;
      x     <= '0;
    end else if (state == SEARCH) begin
      if (hit) begin
        res <= x;
        err <= 1'b0;
      end else if (last_x) begin
        // No x solves it
        res <= '0;
        err <= 1'b1;
      end else begin
        acc <= acc_next;
        x   <= x + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign lane.idle    = (state == IDLE);
  assign lane.done    = (state == HOLD);
  assign lane.result  = res;
  assign lane.error   = err;
  assign lane.tag_out = tag_r;

  // Sequencer only starts an idle lane
  a_start_idle : assert property (@(posedge CLK) disable iff (RST)
    lane.start |-> state == IDLE);

endmodule

`default_nettype wire

// ==== hdl/ntm_matrix_sequencer.sv ====
// Matrix loop and lane dispatch
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_sequencer import ntm_arith_pkg::*; (
  input wire          CLK,
  input wire          RST,

  // Run control
  input wire          run,
  output logic        busy,
  output logic        fin,

  // Settings
  input wire elem_t   modulo,
  input wire dim_t    size_i,
  input wire dim_t    size_j,

  // Operand read
  output idx_t        rd_idx,
  input wire elem_t   a_elem,
  input wire elem_t   b_elem,

  // Result write
  output logic        res_we,
  output idx_t        res_idx,
  output elem_t       res_data,
  output logic        res_err,

  // Lanes
  ntm_div_lane_if.seq lane0,
  ntm_div_lane_if.seq lane1
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Loop counters
  dim_t i_q;
  dim_t j_q;

  logic       issued_all;
  logic [1:0] outstanding;   // elements in the lanes

  logic can_issue;
  logic issue;
  logic collect;
  logic last_elem;
  logic last_j;

  //////////////////////////////////////////////////////////////////////
  // Dispatch
  //////////////////////////////////////////////////////////////////////

  assign rd_idx    = idx_t'(i_q) * idx_t'(MAX_DIM) + idx_t'(j_q);
  assign last_j    = (j_q == size_j - 1'b1);
  assign last_elem = (i_q == size_i - 1'b1) && last_j;

  // Lower numbered idle lane takes the element
  assign can_issue   = busy && !issued_all;
  assign lane0.start = can_issue && lane0.idle;
  assign lane1.start = can_issue && !lane0.idle && lane1.idle;
  assign issue       = lane0.start || lane1.start;

  // Same operands to both lanes and start picks the lane
  assign lane0.a      = a_elem;
  assign lane0.b      = b_elem;
  assign lane0.modulo = modulo;
  assign lane0.tag    = rd_idx;
  assign lane1.a      = a_elem;
  assign lane1.b      = b_elem;
  assign lane1.modulo = modulo;
  assign lane1.tag    = rd_idx;

  //////////////////////////////////////////////////////////////////////
  // Collection
  //////////////////////////////////////////////////////////////////////

  // Lane 0 first while lane 1 holds its done
  assign lane0.ack = lane0.done;
  assign lane1.ack = lane1.done && !lane0.done;
  assign collect   = lane0.done || lane1.done;

  assign res_we   = collect;
  assign res_idx  = lane0.done ? lane0.tag_out : lane1.tag_out;
  assign res_data = lane0.done ? lane0.result  : lane1.result;
  assign res_err  = lane0.done ? lane0.error   : lane1.error;

  // Last write of the run
  assign fin = busy && issued_all && collect && (outstanding == 2'd1);

  // Loop state
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy        <= 1'b0;
      i_q         <= '0;
      j_q         <= '0;
      issued_all  <= 1'b0;
      outstanding <= '0;
    end else if (!busy) begin
      if (run) begin
        busy        <= 1'b1;
        i_q         <= '0;
        j_q         <= '0;
        issued_all  <= 1'b0;
        outstanding <= '0;
      end
    end else begin
      // Step j, then i
      if (issue) begin
        if (last_elem) begin
          issued_all <= 1'b1;
        end else if (last_j) begin
          j_q <= '0;
          i_q <= i_q + 1'b1;
        end else begin
          j_q <= j_q + 1'b1;
        end
      end
      case ({issue, collect})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
      if (fin) begin
        busy <= 1'b0;
      end
    end
  end

  // Held lane 1 result waits unchanged for its ack
  a_hold_ack : assert property (@(posedge CLK) disable iff (RST)
    (lane1.done && !lane1.ack) |=>
      lane1.done && $stable(lane1.result) && $stable(lane1.tag_out));

  // An acked lane is free on the next cycle
  a_ack_idle : assert property (@(posedge CLK) disable iff (RST)
    (lane0.ack |=> lane0.idle) and (lane1.ack |=> lane1.idle));

  // Lanes finish only inside a run
  a_we_busy : assert property (@(posedge CLK) disable iff (RST)
    res_we |-> busy);

endmodule

`default_nettype wire

// ==== hdl/ntm_apb_regs.sv ====
// APB registers and matrix storage
`timescale 1ns/100ps
`default_nettype none

module ntm_apb_regs
  import ntm_arith_pkg::*;
  import ntm_apb_pkg::*;
(
  input wire                CLK,
  input wire                RST,

  // APB slave
  input wire                psel,
  input wire                penable,
  input wire                pwrite,
  input wire apb_addr_t     paddr,
  input wire [PDATA_W-1:0]  pwdata,
  output logic [PDATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr,

  // To the sequencer
  output logic              run,
  output elem_t             modulo,
  output dim_t              size_i,
  output dim_t              size_j,
  input wire idx_t          rd_idx,
  output elem_t             a_elem,
  output elem_t             b_elem,

  // From the sequencer
  input wire                res_we,
  input wire idx_t          res_idx,
  input wire elem_t         res_data,
  input wire                res_err,
  input wire                busy,
  input wire                fin,
  output logic              done_irq
);

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  logic       access;
  logic       wr;
  logic       aligned;
  logic [1:0] win_sel;
  idx_t       win_idx;
  logic       hit_ctrl;
  logic       hit_status;
  logic       hit_mod;
  logic       hit_size;
  logic       in_a;
  logic       in_b;
  logic       in_r;
  logic       unmapped;
  logic       wr_bad;
  logic       wr_ok;
  elem_t      wr_elem;
  dim_t       wr_size_i;
  dim_t       wr_size_j;
  logic       done_q;
  logic       err_q;

  elem_t a_mem [ELEMS];
  elem_t b_mem [ELEMS];
  elem_t r_mem [ELEMS];

  assign pready = 1'b1;
  assign access = psel && penable;
  assign wr     = access && pwrite;

  // Top two address bits pick the window
  assign aligned = (paddr[1:0] == 2'b00);
  assign win_sel = paddr[ADDR_W-1 -: 2];
  assign win_idx = idx_t'(paddr[ADDR_W-3:2]);

  assign hit_ctrl   = (paddr == CTRL_OFS);
  assign hit_status = (paddr == STATUS_OFS);
  assign hit_mod    = (paddr == MOD_OFS);
  assign hit_size   = (paddr == SIZE_OFS);
  assign in_a       = aligned && (win_sel == A_BASE[ADDR_W-1 -: 2]);
  assign in_b       = aligned && (win_sel == B_BASE[ADDR_W-1 -: 2]);
  assign in_r       = aligned && (win_sel == R_BASE[ADDR_W-1 -: 2]);
  assign unmapped   = !(hit_ctrl || hit_status || hit_mod || hit_size || in_a || in_b || in_r);

  assign wr_elem   = pwdata[DATA_W-1:0];
  assign wr_size_i = pwdata[2:0];
  assign wr_size_j = pwdata[6:4];

  // Rejected writes leave every register as it was
  assign wr_bad = unmapped || in_r
               || (busy && (in_a || in_b || hit_mod || hit_size))
               || (hit_mod && wr_elem < 2)
               || (hit_size && (wr_size_i == 0 || wr_size_i > MAX_DIM
                                || wr_size_j == 0 || wr_size_j > MAX_DIM));

  assign pslverr = access && (unmapped || (pwrite && wr_bad));
  assign wr_ok   = wr && !wr_bad;

  // START while busy is dropped quietly
  assign run = wr_ok && hit_ctrl && pwdata[0] && !busy;

  //////////////////////////////////////////////////////////////////////
  // Control and status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo   <= elem_t'(2);
      size_i   <= dim_t'(1);
      size_j   <= dim_t'(1);
      done_q   <= 1'b0;
      err_q    <= 1'b0;
      done_irq <= 1'b0;
    end else begin
      if (wr_ok && hit_mod) begin
        modulo <= wr_elem;
      end
      if (wr_ok && hit_size) begin
        size_i <= wr_size_i;
        size_j <= wr_size_j;
      end
      // Sticky bits, set wins over write-one clear
      if (fin) begin
        done_q <= 1'b1;
      end else if (wr_ok && hit_status && pwdata[1]) begin
        done_q <= 1'b0;
      end
      if (res_we && res_err) begin
        err_q <= 1'b1;
      end else if (wr_ok && hit_status && pwdata[2]) begin
        err_q <= 1'b0;
      end
      done_irq <= fin;
    end
  end

  // Matrix arrays
  always_ff @(posedge CLK) begin
    if (wr_ok && in_a) begin
      a_mem[win_idx] <= wr_elem;
    end
    if (wr_ok && in_b) begin
      b_mem[win_idx] <= wr_elem;
    end
    if (res_we) begin
      r_mem[res_idx] <= res_data;
    end
  end

  assign a_elem = a_mem[rd_idx];
  assign b_elem = b_mem[rd_idx];

  // Read mux, CTRL reads as zero
  always_comb begin
    prdata = '0;
    if (hit_status) begin
      prdata[2:0] = {err_q, done_q, busy};
    end else if (hit_mod) begin
      prdata[DATA_W-1:0] = modulo;
    end else if (hit_size) begin
      prdata[2:0] = size_i;
      prdata[6:4] = size_j;
    end else if (in_a) begin
      prdata[DATA_W-1:0] = a_mem[win_idx];
    end else if (in_b) begin
      prdata[DATA_W-1:0] = b_mem[win_idx];
    end else if (in_r) begin
      prdata[DATA_W-1:0] = r_mem[win_idx];
    end
  end

  // Error response only after a proper setup phase
  a_slverr_access : assert property (@(posedge CLK) disable iff (RST)
    pslverr |-> psel && penable && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== hdl/ntm_matrix_divider_top.sv ====
// Matrix modular divider top level
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_divider_top
  import ntm_arith_pkg::*;
  import ntm_apb_pkg::*;
(
  input wire                 CLK,
  input wire                 RST,

  // APB
  input wire                 psel,
  input wire                 penable,
  input wire                 pwrite,
  input wire apb_addr_t      paddr,
  input wire [PDATA_W-1:0]   pwdata,
  output logic [PDATA_W-1:0] prdata,
  output logic               pready,
  output logic               pslverr,

  // End of run
  output logic               done_irq
);

  //////////////////////////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////////////////////////

  logic  run;
  elem_t modulo;
  dim_t  size_i;
  dim_t  size_j;
  idx_t  rd_idx;
  elem_t a_elem;
  elem_t b_elem;
  logic  res_we;
  idx_t  res_idx;
  elem_t res_data;
  logic  res_err;
  logic  busy;
  logic  fin;

  // One link per lane
  ntm_div_lane_if lane0_if ();
  ntm_div_lane_if lane1_if ();

  // Bus side
  ntm_apb_regs regs (
    .CLK      (CLK),
    .RST      (RST),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .run      (run),
    .modulo   (modulo),
    .size_i   (size_i),
    .size_j   (size_j),
    .rd_idx   (rd_idx),
    .a_elem   (a_elem),
    .b_elem   (b_elem),
    .res_we   (res_we),
    .res_idx  (res_idx),
    .res_data (res_data),
    .res_err  (res_err),
    .busy     (busy),
    .fin      (fin),
    .done_irq (done_irq)
  );

  // i/j loop
  ntm_matrix_sequencer sequencer (
    .CLK      (CLK),
    .RST      (RST),
    .run      (run),
    .busy     (busy),
    .fin      (fin),
    .modulo   (modulo),
    .size_i   (size_i),
    .size_j   (size_j),
    .rd_idx   (rd_idx),
    .a_elem   (a_elem),
    .b_elem   (b_elem),
    .res_we   (res_we),
    .res_idx  (res_idx),
    .res_data (res_data),
    .res_err  (res_err),
    .lane0    (lane0_if.seq),
    .lane1    (lane1_if.seq)
  );

  // Two divider lanes
  ntm_modular_divider divider0 (
    .CLK  (CLK),
    .RST  (RST),
    .lane (lane0_if.lane)
  );

  ntm_modular_divider divider1 (
    .CLK  (CLK),
    .RST  (RST),
    .lane (lane1_if.lane)
  );

endmodule

`default_nettype wire

// ==== bench/tb_ntm_matrix_divider.sv ====
// Matrix modular divider testbench
`timescale 1ns/100ps
`default_nettype none

module tb_ntm_matrix_divider
  import ntm_arith_pkg::*;
  import ntm_apb_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // Setup
  //////////////////////////////////////////////////////////////////////

  localparam int HALF = 5;

  // Elements times (M + 4) cycles for each run, plus 2 us
  localparam int WATCHDOG_NS =
    (ELEMS * (251 + 4) + 6 * (12 + 4) + 9 * (97 + 4) + ELEMS * (251 + 4)) * 10 + 2000;

  logic               CLK;
  logic               RST;
  logic               psel;
  logic               penable;
  logic               pwrite;
  apb_addr_t          paddr;
  logic [PDATA_W-1:0] pwdata;
  logic [PDATA_W-1:0] prdata;
  logic               pready;
  logic               pslverr;
  logic               done_irq;

  int errors;
  int assert_errors;
  int irq_count;

  // Operands and the expected R contents
  elem_t a_vals [ELEMS];
  elem_t b_vals [ELEMS];
  elem_t exp_r  [ELEMS];
  bit    r_known[ELEMS];

  ntm_matrix_divider_top UUT (
    .CLK      (CLK),
    .RST      (RST),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .done_irq (done_irq)
  );

  always #HALF CLK = ~CLK;

  // done_irq is one cycle wide, so one count per pulse
  always @(negedge CLK) begin
    if (!RST && done_irq) begin
      irq_count++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus checks
  //////////////////////////////////////////////////////////////////////

  a_irq_pulse : assert property (@(posedge CLK) disable iff (RST) done_irq |=> !done_irq)
    else begin
      assert_errors++;
      $display("done_irq stayed high for more than one cycle at %0t", $time);
    end

  a_pready_high : assert property (@(posedge CLK) disable iff (RST) pready)
    else begin
      assert_errors++;
      $display("pready dropped low at %0t", $time);
    end

  a_slverr_phase : assert property (@(posedge CLK) disable iff (RST)
    pslverr |-> psel && penable)
    else begin
      assert_errors++;
      $display("pslverr raised outside an access phase at %0t", $time);
    end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // Setup, access, then one idle cycle
  task automatic apb_transfer(input logic is_write, input apb_addr_t addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
    @(negedge CLK);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = is_write;
    paddr   = addr;
    pwdata  = data;
    @(negedge CLK);
    penable = 1'b1;
    // Response is settled well before the access edge
    #1;
    rdata = prdata;
    err   = pslverr;
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic write_reg(input apb_addr_t addr, input logic [31:0] data,
                           input logic want_err, input string name);
    logic err;
    apb_write(addr, data, err);
    check_value({name, " pslverr"}, err, want_err);
  endtask

  task automatic read_reg(input apb_addr_t addr, input logic [31:0] want,
                          input string name);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_value({name, " pslverr"}, err, 1'b0);
    check_value(name, data, want);
  endtask

  // Smallest x in 0..M-1 with a*x = b mod M
  function automatic elem_t smallest_x(input elem_t a, input elem_t b, input elem_t m,
                                       output logic no_sol);
    int x;
    no_sol     = 1'b1;
    smallest_x = '0;
    for (x = 0; x < int'(m); x++) begin
      if (no_sol && ((int'(a) * x) % int'(m)) == (int'(b) % int'(m))) begin
        smallest_x = elem_t'(x);
        no_sol     = 1'b0;
      end
    end
  endfunction

  task automatic fill_operands(input int m, input int a_min);
    int k;
    for (k = 0; k < ELEMS; k++) begin
      a_vals[k] = elem_t'(a_min + ($urandom % (m - a_min)));
      b_vals[k] = elem_t'($urandom % m);
    end
  endtask

  // Load, start, wait for done_irq, then read back
  task automatic run_matrix(input elem_t m, input int si, input int sj,
                            input logic poke_busy);
    int   i;
    int   j;
    int   k;
    int   limit;
    int   waited;
    int   irq_before;
    logic no_sol;
    logic exp_err;
    exp_err = 1'b0;
    write_reg(MOD_OFS, m, 1'b0, "MOD");
    write_reg(SIZE_OFS, sj * 16 + si, 1'b0, "SIZE");
    for (i = 0; i < si; i++) begin
      for (j = 0; j < sj; j++) begin
        k = i * MAX_DIM + j;
        write_reg(apb_addr_t'(A_BASE + 4 * k), a_vals[k], 1'b0, "A write");
        write_reg(apb_addr_t'(B_BASE + 4 * k), b_vals[k], 1'b0, "B write");
        exp_r[k]   = smallest_x(a_vals[k], b_vals[k], m, no_sol);
        r_known[k] = 1'b1;
        exp_err    = exp_err | no_sol;
      end
    end
    // Clear sticky done and error
    write_reg(STATUS_OFS, 32'h6, 1'b0, "STATUS clear");
    read_reg(STATUS_OFS, 32'h0, "STATUS after clear");
    irq_before = irq_count;
    write_reg(CTRL_OFS, 32'h1, 1'b0, "CTRL");
    read_reg(STATUS_OFS, 32'h1, "STATUS while running");
    if (poke_busy) begin
      write_reg(A_BASE, a_vals[0] ^ 12'h5a5, 1'b1, "A write while busy");
      write_reg(MOD_OFS, 32'h7, 1'b1, "MOD write while busy");
    end
    limit  = si * sj * (int'(m) + 4) + 20;
    waited = 0;
    while (irq_count == irq_before && waited < limit) begin
      @(negedge CLK);
      waited++;
    end
    if (irq_count == irq_before) begin
      errors++;
      $display("No done_irq within %0d cycles of START at %0t", limit, $time);
    end
    repeat (3) @(negedge CLK);
    check_value("done_irq pulse count", irq_count - irq_before, 1);
    read_reg(STATUS_OFS, {29'h0, exp_err, 1'b1, 1'b0}, "STATUS after run");
    for (k = 0; k < ELEMS; k++) begin
      if (r_known[k]) begin
        read_reg(apb_addr_t'(R_BASE + 4 * k), exp_r[k], $sformatf("R[%0d]", k));
      end
    end
    // Rejected writes left A and MOD alone
    if (poke_busy) begin
      read_reg(A_BASE, a_vals[0], "A[0]");
      read_reg(MOD_OFS, m, "MOD");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          k;
    logic [31:0] data;
    logic        err;
    CLK           = 1'b0;
    RST           = 1'b1;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    errors        = 0;
    assert_errors = 0;
    irq_count     = 0;
    for (k = 0; k < ELEMS; k++) begin
      r_known[k] = 1'b0;
    end
    void'($urandom(32'ha5a1_bb59));
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Full 4x4 with a prime modulus
    fill_operands(251, 1);
    run_matrix(12'd251, 4, 4, 1'b0);

    // 2x3 with A sharing factors with 12
    fill_operands(12, 1);
    a_vals[0] = 12'd6;
    b_vals[0] = 12'd3;
    a_vals[1] = 12'd4;
    b_vals[1] = 12'd8;
    a_vals[2] = 12'd9;
    b_vals[2] = 12'd6;
    run_matrix(12'd12, 2, 3, 1'b0);

    // Rejected register writes
    write_reg(MOD_OFS, 32'h1, 1'b1, "MOD=1");
    read_reg(MOD_OFS, 32'd12, "MOD");
    write_reg(SIZE_OFS, 32'h30, 1'b1, "SIZE_I=0");
    write_reg(SIZE_OFS, 32'h35, 1'b1, "SIZE_I=5");
    write_reg(SIZE_OFS, 32'h52, 1'b1, "SIZE_J=5");
    write_reg(SIZE_OFS, 32'h02, 1'b1, "SIZE_J=0");
    read_reg(SIZE_OFS, 32'h32, "SIZE");
    write_reg(8'h10, 32'h1, 1'b1, "unmapped write");
    apb_read(8'h10, data, err);
    check_value("unmapped read pslverr", err, 1'b1);
    write_reg(R_BASE, ~exp_r[0], 1'b1, "R write");
    read_reg(R_BASE, exp_r[0], "R[0]");

    // Single rows and columns
    fill_operands(97, 1);
    run_matrix(12'd97, 1, 4, 1'b0);
    fill_operands(97, 1);
    run_matrix(12'd97, 4, 1, 1'b0);
    fill_operands(97, 1);
    run_matrix(12'd97, 1, 1, 1'b0);

    // Fresh data with writes attempted while busy
    fill_operands(251, 1);
    run_matrix(12'd251, 4, 4, 1'b1);

    $display("Errors: %0d check, %0d assertion", errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/ntm_arith_pkg.sv
hdl/ntm_apb_pkg.sv
hdl/ntm_div_lane_if.sv
hdl/ntm_modular_divider.sv
hdl/ntm_matrix_sequencer.sv
hdl/ntm_apb_regs.sv
hdl/ntm_matrix_divider_top.sv
bench/tb_ntm_matrix_divider.sv
